/* sources.f */
+incdir+include
hdl/mulDivTypesPkg.sv
hdl/apbBusPkg.sv
hdl/apbMulDivRegs.sv
hdl/wallaceMul32.sv
hdl/restoringDiv32.sv
hdl/mulDivCombine.sv
hdl/mulDivApb.sv
tb/mulDivApbTb.sv

/* run.sh */
#!/bin/sh
# Build and run the multiply/divide coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module mulDivApbTb -f sources.f

./obj_dir/VmulDivApbTb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* tb/mulDivApbTb.sv */
`include "mulDiv_cfg.svh"

module mulDivApbTb;
    import mulDivTypesPkg::*;
    import apbBusPkg::*;

    localparam int NUM_VEC    = 21;
    localparam int NUM_RAND   = 40;
    localparam int POLL_LIMIT = 200;

    typedef struct packed {
        mdOp_t      op;
        mdWord_t    opA;
        mdWord_t    opB;
        mdWord_t    expLo;
        mdWord_t    expHi;
        logic [3:0] expFlags;       // busy, divByZero, mulOverflow, resultZero
    } vecEntry_t;

    logic      clk;
    logic      rstN;
    apbReq_t   apbReq;
    apbRsp_t   apbRsp;
    vecEntry_t vecs [NUM_VEC];
    int        errCount;
    int        checkCount;
    logic      timedOut;
    integer    seed;

    mulDivApb UUT (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #2 clk = ~clk;

    task automatic checkVal(input logic [63:0] got, input logic [63:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////
    task automatic busCycle(input logic write, input apbAddr_t addr, input mdWord_t wdata,
                            output mdWord_t rdata, output logic err);
        @(posedge clk);
        #1;
        apbReq.psel    = 1'b1;      // Setup phase
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #1;
        apbReq.penable = 1'b1;      // Access phase
        @(negedge clk);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        checkVal(64'(apbRsp.pready), 64'd1, "PREADY in access phase");
        @(posedge clk);             // Transfer completes here
        #1;
        apbReq = '0;
    endtask

    task automatic apbWrite(input apbAddr_t addr, input mdWord_t data, output logic err);
        mdWord_t unused;
        busCycle(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input apbAddr_t addr, output mdWord_t data, output logic err);
        busCycle(1'b0, addr, '0, data, err);
    endtask

    // Poll STATUS until busy clears
    task automatic pollDone();
        mdWord_t st;
        logic    err;
        logic    busyBit;
        int      iter;
        iter    = 0;
        busyBit = 1'b1;
        while (busyBit && (iter < POLL_LIMIT)) begin
            apbRead(`MD_REG_STATUS, st, err);
            busyBit = st[3];
            iter++;
        end
        if (busyBit) begin
            errCount++;
            timedOut = 1'b1;
            $display("Timeout: busy still set after %0d status polls at time %0t",
                     POLL_LIMIT, $time);
        end
    endtask

    // Full operation through the register interface
    task automatic runOp(input mdOp_t op, input mdWord_t a, input mdWord_t b,
                         output mdWide_t res, output mdWord_t status);
        logic    err;
        mdWord_t lo;
        mdWord_t hi;
        apbWrite(`MD_REG_OPA, a, err);
        checkVal(64'(err), 64'd0, "PSLVERR on OPA write");
        apbWrite(`MD_REG_OPB, b, err);
        checkVal(64'(err), 64'd0, "PSLVERR on OPB write");
        apbWrite(`MD_REG_CTRL, mdWord_t'(op), err);
        checkVal(64'(err), 64'd0, "PSLVERR on CTRL write");
        pollDone();
        if (timedOut) begin
            return;
        end
        apbRead(`MD_REG_RESLO, lo, err);
        apbRead(`MD_REG_RESHI, hi, err);
        apbRead(`MD_REG_STATUS, status, err);
        res = {hi, lo};
    endtask

    // Expected result from plain 64-bit arithmetic, {remainder, quotient} for divides
    task automatic modelOp(input mdOp_t op, input mdWord_t a, input mdWord_t b,
                           output mdWide_t res, output logic [3:0] fl);
        longint sa;
        longint sb;
        longint q;
        longint r;
        logic   dbz;
        logic   ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        dbz = op[1] && (b == 32'd0);
        case (op)
            OP_MULU: res = {32'd0, a} * {32'd0, b};
            OP_MULS: res = sa * sb;
            OP_DIVU: begin
                if (b == 32'd0) begin
                    res = {a, 32'hFFFF_FFFF};
                end else begin
                    res = {a % b, a / b};
                end
            end
            default: begin
                if (b == 32'd0) begin
                    res = {a, 32'hFFFF_FFFF};
                end else begin
                    q   = sa / sb;      // MIN / -1 wraps back to MIN
                    r   = sa % sb;
                    res = {r[31:0], q[31:0]};
                end
            end
        endcase
        if (op[1]) begin
            ovf = 1'b0;
        end else if (op == OP_MULS) begin
            ovf = (res[63:32] != {32{res[31]}});
        end else begin
            ovf = (res[63:32] != 32'd0);
        end
        fl = {1'b0, dbz, ovf, (res == 64'd0)};
    endtask

    ////////////////////////////////////////////////////////////
    // Directed vectors
    ////////////////////////////////////////////////////////////
    task automatic fillTable();
        vecs[0]  = '{OP_MULU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFE, 4'b0010};
        vecs[1]  = '{OP_MULS, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 4'b0000};
        vecs[2]  = '{OP_MULU, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780, 32'h0000_0001, 4'b0010};
        vecs[3]  = '{OP_MULU, 32'h0000_0003, 32'h0000_0005, 32'h0000_000F, 32'h0000_0000, 4'b0000};
        vecs[4]  = '{OP_MULS, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA, 32'hFFFF_FFFF, 4'b0000};
        vecs[5]  = '{OP_MULS, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 32'h4000_0000, 4'b0010};
        vecs[6]  = '{OP_MULU, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000, 32'h0000_0000, 4'b0001};
        vecs[7]  = '{OP_MULS, 32'h7FFF_FFFF, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 4'b0001};
        vecs[8]  = '{OP_MULS, 32'h7FFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFE, 32'h0000_0000, 4'b0010};
        // Divides where the remainder follows the dividend sign
        vecs[9]  = '{OP_DIVU, 32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 32'h0000_0002, 4'b0000};
        vecs[10] = '{OP_DIVS, 32'hFFFF_FF9C, 32'h0000_0007, 32'hFFFF_FFF2, 32'hFFFF_FFFE, 4'b0000};
        vecs[11] = '{OP_DIVS, 32'h0000_0064, 32'hFFFF_FFF9, 32'hFFFF_FFF2, 32'h0000_0002, 4'b0000};
        vecs[12] = '{OP_DIVS, 32'hFFFF_FF9C, 32'hFFFF_FFF9, 32'h0000_000E, 32'hFFFF_FFFE, 4'b0000};
        vecs[13] = '{OP_DIVS, 32'hFFFF_FFEB, 32'h0000_0007, 32'hFFFF_FFFD, 32'h0000_0000, 4'b0000};
        vecs[14] = '{OP_DIVU, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0FFF_FFFF, 32'h0000_000F, 4'b0000};
        vecs[15] = '{OP_DIVU, 32'h0000_0005, 32'h0000_0009, 32'h0000_0000, 32'h0000_0005, 4'b0000};
        vecs[16] = '{OP_DIVU, 32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 32'h0000_0000, 4'b0001};
        // Zero divisor and MIN / -1
        vecs[17] = '{OP_DIVU, 32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_1234, 4'b0100};
        vecs[18] = '{OP_DIVS, 32'h8000_0000, 32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 4'b0100};
        vecs[19] = '{OP_DIVS, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0000, 4'b0000};
        vecs[20] = '{OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 32'h8000_0000, 4'b0000};
    endtask

    // Whole test sequence, left early when a poll times out
    task automatic runTests();
        mdWide_t    res;
        mdWide_t    expRes;
        mdWord_t    status;
        mdWord_t    rd;
        mdWord_t    rnd;
        mdWord_t    a;
        mdWord_t    b;
        mdOp_t      op;
        logic [3:0] expFl;
        logic       err;

        // Clean state out of reset
        apbRead(`MD_REG_STATUS, rd, err);
        checkVal(64'(rd), 64'd0, "STATUS after reset");
        apbRead(`MD_REG_RESLO, rd, err);
        checkVal(64'(rd), 64'd0, "RESLO after reset");
        apbRead(`MD_REG_RESHI, rd, err);
        checkVal(64'(rd), 64'd0, "RESHI after reset");

        for (int i = 0; i < NUM_VEC; i++) begin
            runOp(vecs[i].op, vecs[i].opA, vecs[i].opB, res, status);
            if (timedOut) begin
                return;
            end
            checkVal(res, {vecs[i].expHi, vecs[i].expLo}, $sformatf("vector %0d result", i));
            checkVal(64'(status), 64'({28'd0, vecs[i].expFlags}),
                     $sformatf("vector %0d status", i));
        end

        ////////////////////////////////////////////////////////////
        // Bus errors and restart while busy
        ////////////////////////////////////////////////////////////
        apbWrite(`MD_REG_OPA, 32'd1000, err);
        apbWrite(`MD_REG_OPB, 32'd3, err);
        apbWrite(`MD_REG_CTRL, mdWord_t'(OP_DIVU), err);
        apbRead(`MD_REG_STATUS, rd, err);
        checkVal(64'(rd[3]), 64'd1, "busy during divide");
        apbWrite(`MD_REG_CTRL, mdWord_t'(OP_MULU), err);
        checkVal(64'(err), 64'd1, "PSLVERR on CTRL write while busy");
        apbRead(`MD_REG_CTRL, rd, err);
        checkVal(64'(rd), 64'(OP_DIVU), "opcode kept after rejected write");
        apbRead(5'h18, rd, err);
        checkVal(64'(err), 64'd1, "PSLVERR on read of offset 0x18");
        apbWrite(5'h18, 32'h5555_AAAA, err);
        checkVal(64'(err), 64'd1, "PSLVERR on write of offset 0x18");
        apbWrite(`MD_REG_STATUS, 32'hFFFF_FFFF, err);
        checkVal(64'(err), 64'd1, "PSLVERR on STATUS write");
        pollDone();
        if (timedOut) begin
            return;
        end
        apbRead(`MD_REG_RESLO, rd, err);
        checkVal(64'(rd), 64'd333, "quotient after rejected restart");
        apbRead(`MD_REG_RESHI, rd, err);
        checkVal(64'(rd), 64'd1, "remainder after rejected restart");

        // Random operands with some zero and some short divisors
        for (int n = 0; n < NUM_RAND; n++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            op  = mdOp_t'(rnd[1:0]);
            if (rnd[4:2] == 3'd0) begin
                b = 32'd0;
            end else if (rnd[7:5] == 3'd1) begin
                b = b >> 20;
            end
            runOp(op, a, b, res, status);
            if (timedOut) begin
                return;
            end
            modelOp(op, a, b, expRes, expFl);
            checkVal(res, expRes, $sformatf("random %0d op %0d result", n, op));
            checkVal(64'(status), 64'({28'd0, expFl}), $sformatf("random %0d status", n));
        end
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        apbReq     = '0;
        errCount   = 0;
        checkCount = 0;
        timedOut   = 1'b0;
        seed       = 33653;
        fillTable();

        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;

        runTests();

        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* hdl/mulDivApb.sv */
module mulDivApb (
    input  logic               clk,
    input  logic               rstN,
    input  apbBusPkg::apbReq_t apbReq,
    output apbBusPkg::apbRsp_t apbRsp
);
    import mulDivTypesPkg::*;

    mdReq_t    mdReq;
    logic      start;
    logic      done;
    mdRes_t    mulRes;
    mdRes_t    divRes;
    mdWide_t   result;
    mdStatus_t flags;

    apbMulDivRegs uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .mdReq  (mdReq),
        .start  (start),
        .done   (done),
        .result (result),
        .flags  (flags)
    );

    // Both units see every start, each filters on opcode
    wallaceMul32 uMul (
        .clk    (clk),
        .rstN   (rstN),
        .mdReq  (mdReq),
        .start  (start),
        .mulRes (mulRes)
    );

    restoringDiv32 uDiv (
        .clk    (clk),
        .rstN   (rstN),
        .mdReq  (mdReq),
        .start  (start),
        .divRes (divRes)
    );

    mulDivCombine uCombine (
        .clk    (clk),
        .rstN   (rstN),
        .mulRes (mulRes),
        .divRes (divRes),
        .result (result),
        .flags  (flags),
        .done   (done)
    );

endmodule

/* hdl/mulDivCombine.sv */
`include "mulDiv_cfg.svh"

module mulDivCombine (
    input  logic                      clk,
    input  logic                      rstN,
    input  mulDivTypesPkg::mdRes_t    mulRes,
    input  mulDivTypesPkg::mdRes_t    divRes,
    output mulDivTypesPkg::mdWide_t   result,
    output mulDivTypesPkg::mdStatus_t flags,
    output logic                      done
);
    import mulDivTypesPkg::*;

    localparam int DW = `MD_DATA_W;

    mdRes_t  pick;
    mdWord_t loWord;
    mdWord_t hiWord;
    logic    overflow;

    assign pick   = mulRes.valid ? mulRes : divRes;
    assign loWord = pick.value[DW-1:0];
    assign hiWord = pick.value[2*DW-1:DW];

    // High word must be pure extension of the low word
    always_comb begin
        if (pick.isDiv) begin
            overflow = 1'b0;
        end else if (pick.signedOp) begin
            overflow = (hiWord != {DW{loWord[DW-1]}});
        end else begin
            overflow = (hiWord != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= pick.valid;
            if (pick.valid) begin
                result <= pick.value;
                flags  <= '{busy: 1'b0,                 // Owned by the register block
                            divByZero: pick.divByZero,
                            mulOverflow: overflow,
                            resultZero: (pick.value == '0)};
            end
        end
    end

    aOneSource: assert property (@(posedge clk) disable iff (!rstN)
        !(mulRes.valid && divRes.valid));

endmodule

/* hdl/restoringDiv32.sv */
`include "mulDiv_cfg.svh"

module restoringDiv32 (
    input  logic                   clk,
    input  logic                   rstN,
    input  mulDivTypesPkg::mdReq_t mdReq,
    input  logic                   start,
    output mulDivTypesPkg::mdRes_t divRes
);
    import mulDivTypesPkg::*;

    localparam int DW    = `MD_DATA_W;
    localparam int CNT_W = $clog2(`MD_DIV_STEPS);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } divState_t;

    divState_t   state;
    logic [CNT_W-1:0] stepCnt;
    logic        divGo;
    logic        isSigned;
    logic        negA;
    logic        negB;
    mdWord_t     magA;
    mdWord_t     magB;
    mdWord_t     quo;           // Dividend shifts out, quotient shifts in
    mdWord_t     divisor;
    logic [DW:0] rem;
    logic [DW:0] shifted;
    logic [DW:0] trial;
    logic        negQ;
    logic        negR;
    logic        zeroDiv;
    logic        signedQ;
    mdWord_t     quoOut;
    mdWord_t     remOut;

    assign divGo    = start && mdReq.op[1];
    assign isSigned = mdReq.op[0];
    assign negA     = isSigned && mdReq.opA[DW-1];
    assign negB     = isSigned && mdReq.opB[DW-1];
    assign magA     = negA ? -mdReq.opA : mdReq.opA;
    assign magB     = negB ? -mdReq.opB : mdReq.opB;

    // Trial subtract for this step
    assign shifted = {rem[DW-1:0], quo[DW-1]};
    assign trial   = shifted - {1'b0, divisor};

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (divGo) begin
                        state   <= (mdReq.opB == '0) ? FIX : RUN;  // Zero divisor skips loop
                        stepCnt <= '0;
                    end
                end
                RUN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == CNT_W'(`MD_DIV_STEPS - 1)) begin
                        state <= FIX;
                    end
                end
                FIX:     state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == IDLE && divGo) begin
            signedQ <= isSigned;
            if (mdReq.opB == '0) begin
                quo     <= '1;                      // RISC-V divide by zero
                rem     <= {1'b0, mdReq.opA};
                negQ    <= 1'b0;
                negR    <= 1'b0;
                zeroDiv <= 1'b1;
            end else begin
                quo     <= magA;
                rem     <= '0;
                divisor <= magB;
                negQ    <= negA ^ negB;
                negR    <= negA;                    // Remainder follows dividend
                zeroDiv <= 1'b0;
            end
        end else if (state == RUN) begin
            quo <= {quo[DW-2:0], !trial[DW]};
            rem <= trial[DW] ? shifted : trial;     // Restore on borrow
        end
    end

    // Sign restore
    assign quoOut = negQ ? -quo : quo;
    assign remOut = negR ? -rem[DW-1:0] : rem[DW-1:0];

    assign divRes = '{valid: (state == FIX), value: {remOut, quoOut},
                      signedOp: signedQ, isDiv: 1'b1, divByZero: zeroDiv};

    // Either the short zero-divisor path or the full step count
    aDivTiming: assert property (@(posedge clk) disable iff (!rstN)
        divRes.valid |-> (($past(divGo) && ($past(mdReq.opB) == '0))
                          || $past(divGo, `MD_DIV_STEPS + 1)));

endmodule

/* hdl/wallaceMul32.sv */
`include "mulDiv_cfg.svh"

module wallaceMul32 (
    input  logic                   clk,
    input  logic                   rstN,
    input  mulDivTypesPkg::mdReq_t mdReq,
    input  logic                   start,
    output mulDivTypesPkg::mdRes_t mulRes
);
    import mulDivTypesPkg::*;

    localparam int DW     = `MD_DATA_W;
    localparam int WW     = 2 * `MD_DATA_W;
    localparam int PP_N   = DW / 2 + 1;     // 17 groups incl. top guard
    localparam int MULT_W = DW + 3;         // Holds 2A with its sign

    typedef struct packed {
        mdWide_t s;
        mdWide_t c;
    } csaOut_t;

    logic              mulGo;
    logic              isSigned;
    logic [MULT_W-1:0] aExt;
    logic [MULT_W-1:0] a2Ext;
    logic [DW+2:0]     bExt;
    logic [PP_N-1:0]   negBits;
    mdWide_t           pp [PP_N];
    mdWide_t           corr;
    csaOut_t           l1 [6];
    csaOut_t           l2 [4];
    csaOut_t           l3 [2];
    csaOut_t           l4 [2];
    csaOut_t           l5;
    csaOut_t           l6;
    mdWide_t           product;
    logic              validQ;
    logic              signedQ;
    mdWide_t           prodQ;

    // One row of full adders, carry moves up a bit
    function automatic csaOut_t csa(input mdWide_t x, input mdWide_t y, input mdWide_t z);
        csaOut_t r;
        r.s = x ^ y ^ z;
        r.c = ((x & y) | (x & z) | (y & z)) << 1;
        return r;
    endfunction

    assign mulGo    = start && !mdReq.op[1];
    assign isSigned = (mdReq.op == OP_MULS);

    assign aExt  = {{3{isSigned & mdReq.opA[DW-1]}}, mdReq.opA};
    assign a2Ext = aExt << 1;
    assign bExt  = {{2{isSigned & mdReq.opB[DW-1]}}, mdReq.opB, 1'b0};  // Implicit b[-1]

    ////////////////////////////////////////////////////////////
    // Radix-4 Booth partial products
    ////////////////////////////////////////////////////////////
    genvar i;
    generate
        for (i = 0; i < PP_N; i++) begin : gBooth
            logic [2:0]        grp;
            logic              zero;
            logic              two;
            logic              neg;
            logic [MULT_W-1:0] mag;
            logic [MULT_W-1:0] sel;

            assign grp  = bExt[2*i+2 -: 3];
            assign zero = (grp == 3'b000) || (grp == 3'b111);
            assign two  = (grp == 3'b011) || (grp == 3'b100);
            assign neg  = grp[2] && !zero;
            assign mag  = zero ? '0 : (two ? a2Ext : aExt);
            assign sel  = neg ? ~mag : mag;         // +1 comes in via corr

            assign pp[i]      = mdWide_t'({{(WW - MULT_W){sel[MULT_W-1]}}, sel}) << (2 * i);
            assign negBits[i] = neg;
        end
    endgenerate

    // Two's complement fix bits, one per negated row
    always_comb begin
        corr = '0;
        for (int k = 0; k < PP_N; k++) begin
            corr[2*k] = negBits[k];
        end
    end

    ////////////////////////////////////////////////////////////
    // Wallace reduction, 18 rows down to 2
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int k = 0; k < 5; k++) begin
            l1[k] = csa(pp[3*k], pp[3*k+1], pp[3*k+2]);
        end
        l1[5] = csa(pp[15], pp[16], corr);

        // Sums with sums, carries with carries
        l2[0] = csa(l1[0].s, l1[1].s, l1[2].s);
        l2[1] = csa(l1[3].s, l1[4].s, l1[5].s);
        l2[2] = csa(l1[0].c, l1[1].c, l1[2].c);
        l2[3] = csa(l1[3].c, l1[4].c, l1[5].c);

        l3[0] = csa(l2[0].s, l2[1].s, l2[2].s);
        l3[1] = csa(l2[3].s, l2[0].c, l2[1].c);

        l4[0] = csa(l3[0].s, l3[1].s, l2[2].c);
        l4[1] = csa(l3[0].c, l3[1].c, l2[3].c);

        l5 = csa(l4[0].s, l4[1].s, l4[0].c);
        l6 = csa(l5.s, l5.c, l4[1].c);
    end

    assign product = l6.s + l6.c;     // Final carry-propagate add

    // Output register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= mulGo;
        end
    end

    always_ff @(posedge clk) begin
        if (mulGo) begin
            prodQ   <= product;
            signedQ <= isSigned;
        end
    end

    assign mulRes = '{valid: validQ, value: prodQ, signedOp: signedQ,
                      isDiv: 1'b0, divByZero: 1'b0};

    aMulPulse: assert property (@(posedge clk) disable iff (!rstN)
        mulRes.valid |=> !mulRes.valid);

endmodule

/* hdl/apbMulDivRegs.sv */
`include "mulDiv_cfg.svh"

module apbMulDivRegs (
    input  logic                      clk,
    input  logic                      rstN,
    input  apbBusPkg::apbReq_t        apbReq,
    output apbBusPkg::apbRsp_t        apbRsp,
    output mulDivTypesPkg::mdReq_t    mdReq,
    output logic                      start,
    input  logic                      done,
    input  mulDivTypesPkg::mdWide_t   result,
    input  mulDivTypesPkg::mdStatus_t flags
);
    import mulDivTypesPkg::*;

    localparam int DW = `MD_DATA_W;

    logic      access;
    logic      wrAccess;
    logic      hitAny;
    logic      isCtrl;
    logic      roReg;
    logic      slvErr;
    logic      wrOk;
    logic      ctrlGo;
    logic      busyQ;
    logic      busy;
    mdWord_t   opA;
    mdWord_t   opB;
    mdOp_t     op;
    mdStatus_t statusNow;
    mdWord_t   rdData;

    assign access   = apbReq.psel && apbReq.penable;    // Access phase
    assign wrAccess = access && apbReq.pwrite;

    // Busy drops in the done cycle itself
    assign busy = busyQ && !done;

    assign statusNow = '{busy: busy,
                         divByZero: flags.divByZero,
                         mulOverflow: flags.mulOverflow,
                         resultZero: flags.resultZero};

    ////////////////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        rdData = '0;
        hitAny = 1'b1;
        isCtrl = 1'b0;
        roReg  = 1'b0;
        case (apbReq.paddr)
            `MD_REG_CTRL: begin
                rdData = mdWord_t'(op);
                isCtrl = 1'b1;
            end
            `MD_REG_OPA: rdData = opA;
            `MD_REG_OPB: rdData = opB;
            `MD_REG_STATUS: begin
                rdData = mdWord_t'(statusNow);
                roReg  = 1'b1;
            end
            `MD_REG_RESLO: begin
                rdData = result[DW-1:0];
                roReg  = 1'b1;
            end
            `MD_REG_RESHI: begin
                rdData = result[2*DW-1:DW];
                roReg  = 1'b1;
            end
            default: hitAny = 1'b0;        // Hole in the map
        endcase
    end

    // Bad offset, write to a status/result reg, or restart while busy
    assign slvErr = access && (!hitAny || (apbReq.pwrite && (roReg || (isCtrl && busy))));
    assign wrOk   = wrAccess && !slvErr;
    assign ctrlGo = wrOk && isCtrl;

    assign apbRsp = '{pready: 1'b1,
                      prdata: (access && !apbReq.pwrite) ? rdData : '0,
                      pslverr: slvErr};

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            op    <= OP_MULU;
            start <= 1'b0;
            busyQ <= 1'b0;
        end else begin
            start <= ctrlGo;                // Pulse in the cycle after access
            if (ctrlGo) begin
                op    <= mdOp_t'(apbReq.pwdata[1:0]);
                busyQ <= 1'b1;
            end else if (done) begin
                busyQ <= 1'b0;
            end
        end
    end

    // Operand registers
    always_ff @(posedge clk) begin
        if (wrOk && (apbReq.paddr == `MD_REG_OPA)) begin
            opA <= apbReq.pwdata;
        end
        if (wrOk && (apbReq.paddr == `MD_REG_OPB)) begin
            opB <= apbReq.pwdata;
        end
    end

    assign mdReq = '{opA: opA, opB: opB, op: op};

    // Only an idle block may launch an operation
    aStartIdle: assert property (@(posedge clk) disable iff (!rstN)
        start |-> $rose(busy));

endmodule

/* hdl/apbBusPkg.sv */
`include "mulDiv_cfg.svh"

package apbBusPkg;

    typedef logic [`MD_ADDR_W-1:0] apbAddr_t;
    typedef logic [`MD_DATA_W-1:0] apbData_t;

    // Master to slave
    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    // Slave to master
    typedef struct packed {
        logic     pready;
        apbData_t prdata;
        logic     pslverr;
    } apbRsp_t;

endpackage

/* hdl/mulDivTypesPkg.sv */
`include "mulDiv_cfg.svh"

package mulDivTypesPkg;

    typedef logic [`MD_DATA_W-1:0]   mdWord_t;
    typedef logic [2*`MD_DATA_W-1:0] mdWide_t;

    // Bit 1 picks the divider, bit 0 the signed variant
    typedef enum logic [1:0] {
        OP_MULU = 2'd0,
        OP_MULS = 2'd1,
        OP_DIVU = 2'd2,
        OP_DIVS = 2'd3
    } mdOp_t;

    typedef struct packed {
        mdWord_t opA;
        mdWord_t opB;
        mdOp_t   op;
    } mdReq_t;

    // What a unit hands to the combiner
    typedef struct packed {
        logic    valid;
        mdWide_t value;        // Div: {remainder, quotient}
        logic    signedOp;
        logic    isDiv;
        logic    divByZero;
    } mdRes_t;

    typedef struct packed {
        logic busy;
        logic divByZero;
        logic mulOverflow;
        logic resultZero;
    } mdStatus_t;

endpackage

/* include/mulDiv_cfg.svh */
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// Datapath and bus widths
`define MD_DATA_W       32
`define MD_ADDR_W       5

////////////////////////////////////////////////////////////
// Register map, byte offsets
////////////////////////////////////////////////////////////
`define MD_REG_CTRL     5'h00   // Opcode, write starts
`define MD_REG_OPA      5'h04
`define MD_REG_OPB      5'h08
`define MD_REG_STATUS   5'h0C   // Read only
`define MD_REG_RESLO    5'h10   // Product low / quotient
`define MD_REG_RESHI    5'h14   // Product high / remainder

// One quotient bit per step
`define MD_DIV_STEPS    32

`endif
